//--- testbench/stream_vectors.txt
// dir_last_word: dir 0 = word sent to the DUT, 1 = expected output word
// last 1 marks tlast; first input word of a frame is the command, bit 0 loads the key
0_0_00000000
0_0_0badc0de
0_0_12345678
0_0_9abcdef0
0_0_0f1e2d3c
0_0_4b5a6978
0_0_8796a5b4
0_0_c3d2e1f0
0_1_01020304
1_0_0badc0de
1_0_12345678
1_0_9abcdef0
1_0_0f1e2d3c
1_0_4b5a6978
1_0_8796a5b4
1_0_c3d2e1f0
1_1_01020304
0_0_00000001
0_0_a5a5a5a5
0_0_5a5a5a5a
0_0_ffff0000
0_0_0000ffff
0_0_01234567
0_0_89abcdef
0_0_fedcba98
0_1_76543210
1_0_a486e0c2
1_0_d3f197b5
1_0_0123ba98
1_1_7654cdef
0_0_000000f0
0_0_00000000
0_0_ffffffff
0_0_13579bdf
0_1_2468ace0
1_0_a5a5a5a5
1_0_a5a5a5a5
1_0_eca89bdf
1_1_2468531f

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns -Wno-fatal \
        --top-module tb_stream_whitener -f files.f -o sim_whitener
if [ $? -ne 0 ]; then
        echo "Verilator build failed"
        exit 1
fi

./obj_dir/sim_whitener > sim.log 2>&1
status=$?
cat sim.log
if grep -F -q '** FAIL **' sim.log; then
        exit 1
fi
if [ $status -ne 0 ]; then
        echo "Simulation exited with status $status"
        exit 1
fi
exit 0

//--- files.f
rtl/stream_pkg.sv
rtl/cipher_pkg.sv
rtl/block_ram.sv
rtl/axis_block_packer.sv
rtl/cipher_key_regs.sv
rtl/block_xor_engine.sv
rtl/axis_block_unpacker.sv
rtl/frame_sequencer.sv
rtl/stream_whitener_top.sv
testbench/stream_whitener_sva.sv
testbench/tb_stream_whitener.sv

//--- testbench/tb_stream_whitener.sv
`timescale 1ns/1ns
`default_nettype none

module tb_stream_whitener;

        localparam int buffer_depth = 2;
        localparam int clk_period   = 100;
        localparam int vec_max      = 64;

        logic              s00_axis_aclk;
        logic              rst_n;
        stream_pkg::word_t s_tdata;
        logic              s_tvalid;
        logic              s_tlast;
        logic              s_tready;
        stream_pkg::word_t m_tdata;
        logic              m_tvalid;
        logic              m_tlast;
        logic              m_tready;

        // Vector entry is {dir nibble, last nibble, word}
        logic [39:0]       vectors [vec_max];
        stream_pkg::word_t in_words [$];
        logic              in_last [$];
        stream_pkg::word_t out_words [$];
        logic              out_last [$];
        integer            seed          = 32'h51c;
        int                out_idx       = 0;
        int                cycle_count   = 0;
        int                timeout_limit = 0;

        stream_whitener_top #(.buffer_depth(buffer_depth)) dut (
                .s00_axis_aclk (s00_axis_aclk),
                .rst_n         (rst_n),
                .s_tdata       (s_tdata),
                .s_tvalid      (s_tvalid),
                .s_tlast       (s_tlast),
                .s_tready      (s_tready),
                .m_tdata       (m_tdata),
                .m_tvalid      (m_tvalid),
                .m_tlast       (m_tlast),
                .m_tready      (m_tready)
        );

        bind stream_whitener_top stream_whitener_sva #(.buffer_depth(buffer_depth)) u_sva (
                .s00_axis_aclk (s00_axis_aclk),
                .rst_n         (rst_n),
                .s_tdata       (s_tdata),
                .s_tvalid      (s_tvalid),
                .s_tlast       (s_tlast),
                .s_tready      (s_tready),
                .m_tdata       (m_tdata),
                .m_tvalid      (m_tvalid),
                .m_tlast       (m_tlast),
                .m_tready      (m_tready)
        );

        // ============================================================
        // Reporting
        // ============================================================
        task automatic abort_run(input string reason);
                $display("%s", reason);
                $display("** FAIL **");
                $fatal(1, "Run stopped at %0t ns", $time);
        endtask

        task automatic check_value(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
                if (got !== exp) begin
                        abort_run($sformatf("MISMATCH at %0t ns: %s is %h, expected %h",
                                            $time, what, got, exp));
                end
        endtask

        // One input word, held until the DUT takes it
        task automatic send_word(input stream_pkg::word_t word, input logic last);
                s_tdata  <= word;
                s_tvalid <= 1'b1;
                s_tlast  <= last;
                @(posedge s00_axis_aclk);
                while (!s_tready) begin
                        @(posedge s00_axis_aclk);
                end
        endtask

        initial begin
                s00_axis_aclk = 1'b0;
                forever #(clk_period / 2) s00_axis_aclk = ~s00_axis_aclk;
        end

        // Random back-pressure, roughly three ready cycles in four
        always @(posedge s00_axis_aclk) begin
                if (rst_n) begin
                        m_tready <= ($random(seed) & 3) != 0;
                end
        end

        // ============================================================
        // Output monitor and timeout
        // ============================================================
        always @(posedge s00_axis_aclk) begin
                if (rst_n && m_tvalid && m_tready) begin
                        if (out_idx >= out_words.size()) begin
                                abort_run("DUT sent a word beyond the expected output stream");
                        end else begin
                                check_value("m_tdata", m_tdata, out_words[out_idx]);
                                check_value("m_tlast", {31'b0, m_tlast},
                                            {31'b0, out_last[out_idx]});
                                out_idx++;
                        end
                end
        end

        always @(posedge s00_axis_aclk) begin
                cycle_count <= cycle_count + 1;
                if (dut.u_sva.fail_count != 0) begin
                        abort_run("A bound port assertion failed");
                end else if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
                        abort_run($sformatf("Timeout after %0d cycles, output stream incomplete",
                                            cycle_count));
                end
        end

        initial begin
                rst_n    = 1'b0;
                s_tdata  = '0;
                s_tvalid = 1'b0;
                s_tlast  = 1'b0;
                m_tready = 1'b0;
                for (int i = 0; i < vec_max; i++) begin
                        vectors[i] = {8'hf0, 32'(i)};
                end
                $readmemh("testbench/stream_vectors.txt", vectors);
                for (int i = 0; i < vec_max; i++) begin
                        if (vectors[i][39:36] == 4'h0) begin
                                in_words.push_back(vectors[i][31:0]);
                                in_last.push_back(vectors[i][32]);
                        end else if (vectors[i][39:36] == 4'h1) begin
                                out_words.push_back(vectors[i][31:0]);
                                out_last.push_back(vectors[i][32]);
                        end
                end
                if (in_words.size() == 0 || out_words.size() == 0) begin
                        abort_run("Vector file held no input or no expected output words");
                end
                timeout_limit = 20 * (in_words.size() + out_words.size());

                repeat (8) @(posedge s00_axis_aclk);
                rst_n <= 1'b1;
                @(posedge s00_axis_aclk);
                foreach (in_words[i]) begin
                        send_word(in_words[i], in_last[i]);
                end
                s_tvalid <= 1'b0;
                s_tlast  <= 1'b0;

                while (out_idx < out_words.size()) begin
                        @(posedge s00_axis_aclk);
                end
                // Idle tail, any stray word is caught by the monitor
                repeat (10) @(posedge s00_axis_aclk);
                if (dut.u_sva.fail_count != 0) begin
                        abort_run("A bound port assertion failed");
                end else begin
                        $display("** PASS **");
                        $finish;
                end
        end

endmodule

`default_nettype wire

//--- testbench/stream_whitener_sva.sv
`timescale 1ns/1ns
`default_nettype none

module stream_whitener_sva #(
        parameter int buffer_depth = 16
) (
        input wire                    s00_axis_aclk,
        input wire                    rst_n,
        input wire stream_pkg::word_t s_tdata,
        input wire                    s_tvalid,
        input wire                    s_tlast,
        input wire                    s_tready,
        input wire stream_pkg::word_t m_tdata,
        input wire                    m_tvalid,
        input wire                    m_tlast,
        input wire                    m_tready
);

        logic        accept;
        logic [15:0] frame_words;
        logic        load_seen;
        int          data_words;
        int          fail_count = 0;

        assign accept = s_tvalid && s_tready;
        // Payload words that reach the input buffer, key block excluded
        assign data_words = int'(frame_words) -
                            (load_seen ? stream_pkg::words_per_block : 0);

        // Words of the current frame seen so far, command word included
        always_ff @(posedge s00_axis_aclk or negedge rst_n) begin
                if (!rst_n) begin
                        frame_words <= '0;
                        load_seen   <= 1'b0;
                end else if (accept) begin
                        if (frame_words == 0) begin
                                load_seen <= s_tdata[cipher_pkg::cmd_load_key_bit];
                        end
                        frame_words <= s_tlast ? '0 : frame_words + 16'd1;
                end
        end

        // ============================================================
        // Port rules
        // ============================================================
        outputs_low_in_reset: assert property (@(posedge s00_axis_aclk)
                !rst_n |-> !s_tready && !m_tvalid)
                else begin
                        fail_count = fail_count + 1;
                        $error("s_tready or m_tvalid high during reset");
                end

        stalled_word_holds: assert property (@(posedge s00_axis_aclk) disable iff (!rst_n)
                m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata) && $stable(m_tlast))
                else begin
                        fail_count = fail_count + 1;
                        $error("output word changed while stalled");
                end

        frame_not_empty: assert property (@(posedge s00_axis_aclk) disable iff (!rst_n)
                accept && s_tlast |-> data_words > 0)
                else begin
                        fail_count = fail_count + 1;
                        $error("frame carries no payload block");
                end

        frame_fits_buffer: assert property (@(posedge s00_axis_aclk) disable iff (!rst_n)
                accept && s_tlast |-> data_words <= buffer_depth * stream_pkg::words_per_block)
                else begin
                        fail_count = fail_count + 1;
                        $error("frame carries more blocks than the input buffer holds");
                end

endmodule

`default_nettype wire

//--- rtl/stream_whitener_top.sv
`timescale 1ns/1ns
`default_nettype none

module stream_whitener_top #(
        parameter int buffer_depth = 16,
        parameter int addr_width   = $clog2(buffer_depth)
) (
        input  wire                    s00_axis_aclk,
        input  wire                    rst_n,
        input  wire stream_pkg::word_t s_tdata,
        input  wire                    s_tvalid,
        input  wire                    s_tlast,
        output logic                   s_tready,
        output stream_pkg::word_t      m_tdata,
        output logic                   m_tvalid,
        output logic                   m_tlast,
        input  wire                    m_tready
);

        logic                  fill_en;
        logic                  start_engine;
        logic                  start_send;
        logic                  frame_stored;
        logic                  done;
        logic                  sent;
        logic [addr_width:0]   block_count;
        logic [addr_width-1:0] pack_addr;
        logic                  pack_wr_en;
        stream_pkg::block_t    pack_data;
        logic                  key_wr_en;
        cipher_pkg::key_t      key_data;
        cipher_pkg::key_t      key;
        logic [addr_width-1:0] in_buf_addr;
        stream_pkg::block_t    in_rd_data;
        logic [addr_width-1:0] engine_in_addr;
        logic [addr_width-1:0] engine_out_addr;
        logic                  engine_wr_en;
        stream_pkg::block_t    engine_data;
        logic [addr_width-1:0] out_buf_addr;
        stream_pkg::block_t    out_rd_data;
        logic [addr_width-1:0] unpack_addr;

        // ============================================================
        // Input side
        // ============================================================
        axis_block_packer #(.addr_width(addr_width)) u_packer (
                .s00_axis_aclk (s00_axis_aclk),
                .rst_n         (rst_n),
                .fill_en       (fill_en),
                .s_tdata       (s_tdata),
                .s_tvalid      (s_tvalid),
                .s_tlast       (s_tlast),
                .s_tready      (s_tready),
                .buf_addr      (pack_addr),
                .buf_wr_en     (pack_wr_en),
                .buf_data      (pack_data),
                .key_wr_en     (key_wr_en),
                .key_data      (key_data),
                .block_count   (block_count),
                .frame_stored  (frame_stored)
        );

        block_ram #(.buffer_depth(buffer_depth), .addr_width(addr_width)) u_in_buf (
                .s00_axis_aclk (s00_axis_aclk),
                .addr          (in_buf_addr),
                .wr_en         (pack_wr_en),
                .wr_data       (pack_data),
                .rd_data       (in_rd_data)
        );

        // ============================================================
        // Key and block engine
        // ============================================================
        cipher_key_regs u_key (
                .s00_axis_aclk (s00_axis_aclk),
                .rst_n         (rst_n),
                .key_wr_en     (key_wr_en),
                .key_data      (key_data),
                .key           (key)
        );

        block_xor_engine #(.addr_width(addr_width)) u_engine (
                .s00_axis_aclk (s00_axis_aclk),
                .rst_n         (rst_n),
                .start         (start_engine),
                .block_count   (block_count),
                .key           (key),
                .in_addr       (engine_in_addr),
                .in_data       (in_rd_data),
                .out_addr      (engine_out_addr),
                .out_wr_en     (engine_wr_en),
                .out_data      (engine_data),
                .done          (done)
        );

        // ============================================================
        // Output side and frame control
        // ============================================================
        block_ram #(.buffer_depth(buffer_depth), .addr_width(addr_width)) u_out_buf (
                .s00_axis_aclk (s00_axis_aclk),
                .addr          (out_buf_addr),
                .wr_en         (engine_wr_en),
                .wr_data       (engine_data),
                .rd_data       (out_rd_data)
        );

        axis_block_unpacker #(.addr_width(addr_width)) u_unpacker (
                .s00_axis_aclk (s00_axis_aclk),
                .rst_n         (rst_n),
                .start         (start_send),
                .block_count   (block_count),
                .buf_addr      (unpack_addr),
                .buf_data      (out_rd_data),
                .m_tdata       (m_tdata),
                .m_tvalid      (m_tvalid),
                .m_tlast       (m_tlast),
                .m_tready      (m_tready),
                .sent          (sent)
        );

        frame_sequencer #(.addr_width(addr_width)) u_seq (
                .s00_axis_aclk   (s00_axis_aclk),
                .rst_n           (rst_n),
                .s_tvalid        (s_tvalid),
                .frame_stored    (frame_stored),
                .done            (done),
                .sent            (sent),
                .fill_en         (fill_en),
                .start_engine    (start_engine),
                .start_send      (start_send),
                .pack_addr       (pack_addr),
                .engine_in_addr  (engine_in_addr),
                .engine_out_addr (engine_out_addr),
                .unpack_addr     (unpack_addr),
                .in_buf_addr     (in_buf_addr),
                .out_buf_addr    (out_buf_addr)
        );

endmodule

`default_nettype wire

//--- rtl/frame_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module frame_sequencer #(
        parameter int addr_width = 4
) (
        input  wire                   s00_axis_aclk,
        input  wire                   rst_n,
        input  wire                   s_tvalid,
        input  wire                   frame_stored,
        input  wire                   done,
        input  wire                   sent,
        output logic                  fill_en,
        output logic                  start_engine,
        output logic                  start_send,
        input  wire [addr_width-1:0]  pack_addr,
        input  wire [addr_width-1:0]  engine_in_addr,
        input  wire [addr_width-1:0]  engine_out_addr,
        input  wire [addr_width-1:0]  unpack_addr,
        output logic [addr_width-1:0] in_buf_addr,
        output logic [addr_width-1:0] out_buf_addr
);

        typedef enum logic [1:0] {
                st_idle,
                st_fill,
                st_process,
                st_send
        } state_t;

        state_t state;

        // ============================================================
        // Buffer address ownership
        // ============================================================
        assign fill_en      = state == st_fill;
        assign in_buf_addr  = (state == st_process) ? engine_in_addr : pack_addr;
        assign out_buf_addr = (state == st_send) ? unpack_addr : engine_out_addr;

        // ============================================================
        // Frame FSM
        // ============================================================
        always_ff @(posedge s00_axis_aclk or negedge rst_n) begin
                if (!rst_n) begin
                        state        <= st_idle;
                        start_engine <= 1'b0;
                        start_send   <= 1'b0;
                end else begin
                        start_engine <= 1'b0;
                        start_send   <= 1'b0;
                        case (state)
                                st_idle: begin
                                        if (s_tvalid) begin
                                                state <= st_fill;
                                        end
                                end
                                st_fill: begin
                                        if (frame_stored) begin
                                                state        <= st_process;
                                                start_engine <= 1'b1;
                                        end
                                end
                                st_process: begin
                                        if (done) begin
                                                state      <= st_send;
                                                start_send <= 1'b1;
                                        end
                                end
                                default: begin
                                        if (sent) begin
                                                state <= st_idle;
                                        end
                                end
                        endcase
                end
        end

endmodule

`default_nettype wire

//--- rtl/axis_block_unpacker.sv
`timescale 1ns/1ns
`default_nettype none

module axis_block_unpacker #(
        parameter int addr_width = 4
) (
        input  wire                     s00_axis_aclk,
        input  wire                     rst_n,
        input  wire                     start,
        input  wire [addr_width:0]      block_count,
        output logic [addr_width-1:0]   buf_addr,
        input  wire stream_pkg::block_t buf_data,
        output stream_pkg::word_t       m_tdata,
        output logic                    m_tvalid,
        output logic                    m_tlast,
        input  wire                     m_tready,
        output logic                    sent
);

        localparam int keep_w = stream_pkg::block_width - stream_pkg::word_width;
        localparam int cnt_w  = $clog2(stream_pkg::words_per_block);

        logic [addr_width-1:0] next_addr;
        logic [addr_width-1:0] blk_idx;
        logic [cnt_w-1:0]      word_cnt;
        logic                  loading;
        logic                  handshake;
        logic                  last_word;
        stream_pkg::block_t    blk_q;

        // Block 0 is addressed together with the start pulse
        assign buf_addr  = start ? '0 : next_addr;
        assign m_tdata   = blk_q[stream_pkg::block_width-1 -: stream_pkg::word_width];
        assign handshake = m_tvalid && m_tready;
        assign last_word = word_cnt == cnt_w'(stream_pkg::words_per_block - 1);
        assign m_tlast   = m_tvalid && last_word && (({1'b0, blk_idx} + 1'b1) == block_count);

        // Word shifter, reloaded from the prefetched block after word 3
        always_ff @(posedge s00_axis_aclk) begin
                if (loading || (handshake && last_word)) begin
                        blk_q <= buf_data;
                end else if (handshake) begin
                        blk_q <= {blk_q[keep_w-1:0], {stream_pkg::word_width{1'b0}}};
                end
        end

        always_ff @(posedge s00_axis_aclk or negedge rst_n) begin
                if (!rst_n) begin
                        next_addr <= '0;
                        blk_idx   <= '0;
                        word_cnt  <= '0;
                        loading   <= 1'b0;
                        m_tvalid  <= 1'b0;
                        sent      <= 1'b0;
                end else begin
                        sent    <= 1'b0;
                        loading <= 1'b0;
                        if (start) begin
                                next_addr <= addr_width'(1);
                                blk_idx   <= '0;
                                word_cnt  <= '0;
                                loading   <= 1'b1;
                        end else if (loading) begin
                                m_tvalid <= 1'b1;
                        end else if (handshake) begin
                                word_cnt <= word_cnt + 1'b1;
                                if (m_tlast) begin
                                        m_tvalid <= 1'b0;
                                        sent     <= 1'b1;
                                end else if (last_word) begin
                                        // Next block is already on the read port
                                        blk_idx   <= blk_idx + 1'b1;
                                        next_addr <= next_addr + 1'b1;
                                end
                        end
                end
        end

endmodule

`default_nettype wire

//--- rtl/block_xor_engine.sv
`timescale 1ns/1ns
`default_nettype none

module block_xor_engine #(
        parameter int addr_width = 4
) (
        input  wire                     s00_axis_aclk,
        input  wire                     rst_n,
        input  wire                     start,
        input  wire [addr_width:0]      block_count,
        input  wire cipher_pkg::key_t   key,
        output logic [addr_width-1:0]   in_addr,
        input  wire stream_pkg::block_t in_data,
        output logic [addr_width-1:0]   out_addr,
        output logic                    out_wr_en,
        output stream_pkg::block_t      out_data,
        output logic                    done
);

        // Three phases per block, plus one drain cycle at the end
        localparam logic [1:0] ph_addr  = 2'd0;
        localparam logic [1:0] ph_read  = 2'd1;
        localparam logic [1:0] ph_write = 2'd2;
        localparam logic [1:0] ph_drain = 2'd3;

        logic                  busy;
        logic [1:0]            phase;
        logic [addr_width-1:0] idx;
        logic                  last_blk;

        assign in_addr   = idx;
        assign out_addr  = idx;
        assign out_wr_en = busy && (phase == ph_write);
        assign last_blk  = ({1'b0, idx} + 1'b1) == block_count;

        // Whitened block, captured as the buffer read returns
        always_ff @(posedge s00_axis_aclk) begin
                if (busy && phase == ph_read) begin
                        out_data <= in_data ^ key;
                end
        end

        always_ff @(posedge s00_axis_aclk or negedge rst_n) begin
                if (!rst_n) begin
                        busy  <= 1'b0;
                        phase <= ph_addr;
                        idx   <= '0;
                        done  <= 1'b0;
                end else begin
                        done <= 1'b0;
                        if (start) begin
                                busy  <= 1'b1;
                                phase <= ph_addr;
                                idx   <= '0;
                        end else if (busy) begin
                                case (phase)
                                        ph_addr:  phase <= ph_read;
                                        ph_read:  phase <= ph_write;
                                        ph_write: begin
                                                if (last_blk) begin
                                                        phase <= ph_drain;
                                                end else begin
                                                        idx   <= idx + 1'b1;
                                                        phase <= ph_addr;
                                                end
                                        end
                                        default: begin
                                                busy  <= 1'b0;
                                                done  <= 1'b1;
                                                phase <= ph_addr;
                                        end
                                endcase
                        end
                end
        end

endmodule

`default_nettype wire

//--- rtl/cipher_key_regs.sv
`timescale 1ns/1ns
`default_nettype none

module cipher_key_regs (
        input  wire                   s00_axis_aclk,
        input  wire                   rst_n,
        input  wire                   key_wr_en,
        input  wire cipher_pkg::key_t key_data,
        output cipher_pkg::key_t      key
);

        // Key persists across frames, zero until the first load
        always_ff @(posedge s00_axis_aclk or negedge rst_n) begin
                if (!rst_n) begin
                        key <= '0;
                end else if (key_wr_en) begin
                        key <= key_data;
                end
        end

endmodule

`default_nettype wire

//--- rtl/axis_block_packer.sv
`timescale 1ns/1ns
`default_nettype none

module axis_block_packer #(
        parameter int addr_width = 4
) (
        input  wire                     s00_axis_aclk,
        input  wire                     rst_n,
        input  wire                     fill_en,
        input  wire stream_pkg::word_t  s_tdata,
        input  wire                     s_tvalid,
        input  wire                     s_tlast,
        output logic                    s_tready,
        output logic [addr_width-1:0]   buf_addr,
        output logic                    buf_wr_en,
        output stream_pkg::block_t      buf_data,
        output logic                    key_wr_en,
        output cipher_pkg::key_t        key_data,
        output logic [addr_width:0]     block_count,
        output logic                    frame_stored
);

        localparam int keep_w = stream_pkg::block_width - stream_pkg::word_width;
        localparam int cnt_w  = $clog2(stream_pkg::words_per_block);

        logic               have_cmd;
        logic               load_key;
        logic               got_last;
        logic [cnt_w-1:0]   word_cnt;
        logic               accept;
        logic               block_done;
        stream_pkg::block_t shift_q;

        assign s_tready   = fill_en && !got_last;
        assign accept     = s_tvalid && s_tready;
        assign block_done = accept && have_cmd &&
                            (word_cnt == cnt_w'(stream_pkg::words_per_block - 1));

        // Completed block is offered to both the buffer and the key register
        assign buf_data = shift_q;
        assign key_data = shift_q;

        // Payload words enter at the bottom, first word ends up on top
        always_ff @(posedge s00_axis_aclk) begin
                if (accept && have_cmd) begin
                        shift_q <= {shift_q[keep_w-1:0], s_tdata};
                end
        end

        always_ff @(posedge s00_axis_aclk or negedge rst_n) begin
                if (!rst_n) begin
                        have_cmd     <= 1'b0;
                        load_key     <= 1'b0;
                        got_last     <= 1'b0;
                        word_cnt     <= '0;
                        buf_addr     <= '0;
                        buf_wr_en    <= 1'b0;
                        key_wr_en    <= 1'b0;
                        block_count  <= '0;
                        frame_stored <= 1'b0;
                end else begin
                        buf_wr_en    <= 1'b0;
                        key_wr_en    <= 1'b0;
                        frame_stored <= 1'b0;
                        if (!fill_en) begin
                                // Rearm for the next frame
                                have_cmd <= 1'b0;
                                got_last <= 1'b0;
                                word_cnt <= '0;
                        end else if (accept && !have_cmd) begin
                                have_cmd    <= 1'b1;
                                load_key    <= s_tdata[cipher_pkg::cmd_load_key_bit];
                                block_count <= '0;
                        end else if (accept) begin
                                word_cnt <= word_cnt + 1'b1;
                                got_last <= s_tlast;
                                if (block_done) begin
                                        frame_stored <= s_tlast;
                                        if (load_key) begin
                                                // Key block is consumed here and never counted
                                                key_wr_en <= 1'b1;
                                                load_key  <= 1'b0;
                                        end else begin
                                                buf_wr_en   <= 1'b1;
                                                buf_addr    <= block_count[addr_width-1:0];
                                                block_count <= block_count + 1'b1;
                                        end
                                end
                        end
                end
        end

endmodule

`default_nettype wire

//--- rtl/block_ram.sv
`timescale 1ns/1ns
`default_nettype none

module block_ram #(
        parameter int buffer_depth = 16,
        parameter int addr_width   = 4
) (
        input  wire                     s00_axis_aclk,
        input  wire [addr_width-1:0]    addr,
        input  wire                     wr_en,
        input  wire stream_pkg::block_t wr_data,
        output stream_pkg::block_t      rd_data
);

        stream_pkg::block_t mem [buffer_depth];

        // Single port, data appears one cycle after the address
        always_ff @(posedge s00_axis_aclk) begin
                if (wr_en) begin
                        mem[addr] <= wr_data;
                end
                rd_data <= mem[addr];
        end

endmodule

`default_nettype wire

//--- rtl/cipher_pkg.sv
`default_nettype none

package cipher_pkg;

        // Flag positions in the frame command word
        localparam int cmd_load_key_bit = 0;

        // Whitening key, one block wide
        typedef logic [stream_pkg::block_width-1:0] key_t;

endpackage

`default_nettype wire

//--- rtl/stream_pkg.sv
`default_nettype none

package stream_pkg;

        // ============================================================
        // Stream word and buffer block geometry
        // ============================================================
        localparam int word_width      = 32;
        localparam int words_per_block = 4;
        localparam int block_width     = word_width * words_per_block;

        typedef logic [word_width-1:0]  word_t;
        typedef logic [block_width-1:0] block_t;

endpackage

`default_nettype wire
